// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the MMU simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module mmu_tb \
  -f sim.f \
  -o mmu_sim

./obj_dir/mmu_sim

// ==== sim.f ====
+incdir+testbench
src/mmu_pkg.sv
src/dtlb.sv
src/access_check.sv
src/mmu_top.sv
testbench/mmu_tb.sv

// ==== src/access_check.sv ====
`timescale 1ns/10ps
// Page-fault and access-fault decode on the stage-2 physical tag, feeds the MMU response
module access_check (
  input  mmu_pkg::mem_op_e   op_i,
  input  logic               translated_i,
  input  mmu_pkg::pte_leaf_s entry_i,
  input  mmu_pkg::ptag_u     ptag_i,
  input  mmu_pkg::priv_e     priv_mode_i,
  input  logic               mstatus_sum_i,
  input  logic               uncached_mode_i,
  output logic               exc_v_o,
  output mmu_pkg::ecode_e    ecode_o
);
  import mmu_pkg::*;

  logic is_store;
  logic is_fencei;
  logic priv_fault;
  logic write_fault;
  logic page_fault;
  logic uncached_addr;
  logic did_fault;
  logic mode_fault;
  logic access_fault;

  assign is_store  = (op_i == e_op_store);
  assign is_fencei = (op_i == e_op_fencei);

  // S-mode touching user pages needs SUM, U-mode only sees user pages
  assign priv_fault = ((priv_mode_i == e_priv_s) && !mstatus_sum_i && entry_i.u)
                    || ((priv_mode_i == e_priv_u) && !entry_i.u);

  // Dirty bit is never set by hardware here
  assign write_fault = is_store && (!entry_i.w || !entry_i.d);

  assign page_fault = translated_i && (priv_fault || write_fault);

  // Other domains and low memory in domain 0 are uncached
  assign uncached_addr = (ptag_i.dom.did != '0)
                       || (ptag_i.dom.lppn < dram_base_ppn_lp);

  assign did_fault  = (ptag_i.dom.did != '0) && (ptag_i.dom.did != io_did_lp);
  assign mode_fault = uncached_mode_i && !uncached_addr;

  assign access_fault = did_fault || mode_fault;

  assign exc_v_o = !is_fencei && (page_fault || access_fault);

  // Page fault has priority
  always_comb begin
    if (page_fault) begin
      ecode_o = is_store ? e_store_page_fault : e_load_page_fault;
    end else begin
      ecode_o = is_store ? e_store_access_fault : e_load_access_fault;
    end
  end

endmodule

// ==== src/dtlb.sv ====
`timescale 1ns/10ps
// Fully associative data TLB with registered lookup, filled one entry per cycle by the walker
module dtlb (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              flush_i,
  input  logic                              r_v_i,
  input  logic [mmu_pkg::vtag_width_lp-1:0] r_vtag_i,
  input  logic                              w_v_i,
  input  logic [mmu_pkg::vtag_width_lp-1:0] w_vtag_i,
  input  mmu_pkg::pte_leaf_s                w_entry_i,
  output logic                              r_hit_o,
  output mmu_pkg::pte_leaf_s                r_entry_o
);
  import mmu_pkg::*;

  logic [dtlb_els_lp-1:0]       valid_r;
  logic [vtag_width_lp-1:0]     tag_r   [dtlb_els_lp];
  pte_leaf_s                    entry_r [dtlb_els_lp];
  logic [dtlb_idx_width_lp-1:0] victim_r;

  logic [dtlb_els_lp-1:0]       r_match;
  logic [dtlb_els_lp-1:0]       w_match;
  logic                         w_hit;
  logic [dtlb_idx_width_lp-1:0] w_match_idx;
  logic [dtlb_idx_width_lp-1:0] w_idx;
  pte_leaf_s                    r_entry_mux;

  // Parallel tag compare for both ports
  always_comb begin
    r_match     = '0;
    w_match     = '0;
    w_match_idx = '0;
    r_entry_mux = '0;
    for (int i = 0; i < dtlb_els_lp; i++) begin
      r_match[i] = valid_r[i] && (tag_r[i] == r_vtag_i);
      w_match[i] = valid_r[i] && (tag_r[i] == w_vtag_i);
      if (r_match[i]) begin
        r_entry_mux = entry_r[i];
      end
      if (w_match[i]) begin
        w_match_idx = dtlb_idx_width_lp'(i);
      end
    end
  end

  assign w_hit = |w_match;

  // Refill of a resident tag replaces it in place
  assign w_idx = w_hit ? w_match_idx : victim_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      victim_r <= '0;
      r_hit_o  <= 1'b0;
    end else begin
      if (flush_i) begin
        valid_r <= '0;
      end else if (w_v_i) begin
        valid_r[w_idx] <= 1'b1;
      end
      // Round-robin victim moves only on a fresh allocation
      if (w_v_i && !w_hit) begin
        victim_r <= victim_r + 1'b1;
      end
      r_hit_o <= r_v_i && (|r_match);
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_v_i) begin
      tag_r[w_idx]   <= w_vtag_i;
      entry_r[w_idx] <= w_entry_i;
    end
    if (r_v_i) begin
      r_entry_o <= r_entry_mux;
    end
  end

  // In-place refill must keep every tag resident at most once
  a_match_onehot: assert property (
    @(posedge clk_i) disable iff (reset_i)
    r_v_i |-> $onehot0(r_match)
  );

endmodule

// ==== src/mmu_pkg.sv ====
// Shared widths, encodings and entry types for the data-side MMU, imported by every RTL block
package mmu_pkg;

  // Sv39 virtual address split
  localparam int vaddr_width_lp       = 39;
  localparam int page_offset_width_lp = 12;
  localparam int vtag_width_lp        = vaddr_width_lp - page_offset_width_lp;

  // 40-bit physical address, domain id at the top of the tag
  localparam int ptag_width_lp  = 28;
  localparam int did_width_lp   = 3;
  localparam int lppn_width_lp  = ptag_width_lp - did_width_lp;

  localparam logic [did_width_lp-1:0] io_did_lp = 3'd1;

  // Page of 0x8000_0000, start of cached memory in domain 0
  localparam logic [lppn_width_lp-1:0] dram_base_ppn_lp = 25'h008_0000;

  localparam int dtlb_els_lp       = 8;
  localparam int dtlb_idx_width_lp = 3;

  typedef enum logic [1:0] {
    e_priv_u = 2'b00,
    e_priv_s = 2'b01,
    e_priv_m = 2'b11
  } priv_e;

  typedef enum logic [1:0] {
    e_op_load   = 2'b00,
    e_op_store  = 2'b01,
    e_op_fencei = 2'b10
  } mem_op_e;

  // RISC-V mcause values for data-side faults
  typedef enum logic [3:0] {
    e_load_access_fault  = 4'd5,
    e_store_access_fault = 4'd7,
    e_load_page_fault    = 4'd13,
    e_store_page_fault   = 4'd15
  } ecode_e;

  // Leaf PTE bits kept in the TLB
  typedef struct packed {
    logic [ptag_width_lp-1:0] ptag;
    logic                     u;
    logic                     w;
    logic                     d;
  } pte_leaf_s;

  // Physical tag seen whole or as domain plus local page
  typedef union packed {
    logic [ptag_width_lp-1:0] ppn;
    struct packed {
      logic [did_width_lp-1:0]  did;
      logic [lppn_width_lp-1:0] lppn;
    } dom;
  } ptag_u;

endpackage

// ==== src/mmu_top.sv ====
`timescale 1ns/10ps
// Data-side MMU top, takes load/store/fence.i commands and answers two cycles after acceptance
module mmu_top (
  input  logic                               clk_i,
  input  logic                               reset_i,

  input  logic                               mmu_cmd_v_i,
  input  mmu_pkg::mem_op_e                   mmu_cmd_op_i,
  input  logic [mmu_pkg::vaddr_width_lp-1:0] mmu_cmd_vaddr_i,
  output logic                               mmu_cmd_ready_o,

  input  logic                               chk_poison_i,

  input  mmu_pkg::priv_e                     priv_mode_i,
  input  logic                               mstatus_sum_i,
  input  logic                               translation_en_i,
  input  logic                               uncached_mode_i,

  input  logic                               dtlb_flush_i,
  input  logic                               tlb_fill_v_i,
  input  logic [mmu_pkg::vtag_width_lp-1:0]  tlb_fill_vtag_i,
  input  mmu_pkg::pte_leaf_s                 tlb_fill_entry_i,

  output logic                               mem_resp_v_o,
  output logic [mmu_pkg::ptag_width_lp-1:0]  mem_resp_ptag_o,
  output logic                               mem_resp_miss_o,
  output logic                               mem_resp_exc_v_o,
  output mmu_pkg::ecode_e                    mem_resp_ecode_o,
  output logic [mmu_pkg::vtag_width_lp-1:0]  miss_vtag_o
);
  import mmu_pkg::*;

  logic cmd_accept;
  logic lookup_v;

  // Stage 1
  logic                      s1_v_r;
  mem_op_e                   s1_op_r;
  logic [vaddr_width_lp-1:0] s1_vaddr_r;
  priv_e                     s1_priv_r;
  logic                      s1_sum_r;
  logic                      s1_tr_en_r;
  logic                      s1_uc_mode_r;

  // Stage 2
  logic                      s2_v_r;
  mem_op_e                   s2_op_r;
  logic [vaddr_width_lp-1:0] s2_vaddr_r;
  priv_e                     s2_priv_r;
  logic                      s2_sum_r;
  logic                      s2_tr_en_r;
  logic                      s2_uc_mode_r;
  logic                      s2_hit_r;
  pte_leaf_s                 s2_entry_r;

  logic                      dtlb_hit;
  pte_leaf_s                 dtlb_entry;
  logic [vtag_width_lp-1:0]  s2_vtag;
  ptag_u                     s2_ptag;
  logic                      s2_fencei;
  logic                      chk_exc_v;
  ecode_e                    chk_ecode;

  // Fill owns the TLB port for its cycle
  assign mmu_cmd_ready_o = !tlb_fill_v_i;
  assign cmd_accept      = mmu_cmd_v_i && mmu_cmd_ready_o;
  assign lookup_v        = cmd_accept && (mmu_cmd_op_i != e_op_fencei);

  dtlb dtlb (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .flush_i   (dtlb_flush_i),
    .r_v_i     (lookup_v),
    .r_vtag_i  (mmu_cmd_vaddr_i[vaddr_width_lp-1:page_offset_width_lp]),
    .w_v_i     (tlb_fill_v_i),
    .w_vtag_i  (tlb_fill_vtag_i),
    .w_entry_i (tlb_fill_entry_i),
    .r_hit_o   (dtlb_hit),
    .r_entry_o (dtlb_entry)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v_r <= 1'b0;
      s2_v_r <= 1'b0;
    end else begin
      s1_v_r <= cmd_accept;
      // Poison kills the command on its way out of stage 1
      s2_v_r <= s1_v_r && !chk_poison_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_accept) begin
      s1_op_r      <= mmu_cmd_op_i;
      s1_vaddr_r   <= mmu_cmd_vaddr_i;
      s1_priv_r    <= priv_mode_i;
      s1_sum_r     <= mstatus_sum_i;
      s1_tr_en_r   <= translation_en_i;
      s1_uc_mode_r <= uncached_mode_i;
    end
    if (s1_v_r) begin
      s2_op_r      <= s1_op_r;
      s2_vaddr_r   <= s1_vaddr_r;
      s2_priv_r    <= s1_priv_r;
      s2_sum_r     <= s1_sum_r;
      s2_tr_en_r   <= s1_tr_en_r;
      s2_uc_mode_r <= s1_uc_mode_r;
      s2_hit_r     <= dtlb_hit;
      s2_entry_r   <= dtlb_entry;
    end
  end

  assign s2_vtag   = s2_vaddr_r[vaddr_width_lp-1:page_offset_width_lp];
  assign s2_fencei = (s2_op_r == e_op_fencei);

  // Bare mode passes the virtual page through
  assign s2_ptag.ppn = s2_tr_en_r ? s2_entry_r.ptag : ptag_width_lp'(s2_vtag);

  access_check access_check (
    .op_i            (s2_op_r),
    .translated_i    (s2_tr_en_r),
    .entry_i         (s2_entry_r),
    .ptag_i          (s2_ptag),
    .priv_mode_i     (s2_priv_r),
    .mstatus_sum_i   (s2_sum_r),
    .uncached_mode_i (s2_uc_mode_r),
    .exc_v_o         (chk_exc_v),
    .ecode_o         (chk_ecode)
  );

  assign mem_resp_v_o     = s2_v_r;
  assign mem_resp_ptag_o  = s2_ptag.ppn;
  assign mem_resp_miss_o  = s2_v_r && !s2_fencei && s2_tr_en_r && !s2_hit_r;
  // Checker result only counts with a usable physical tag
  assign mem_resp_exc_v_o = s2_v_r && (!s2_tr_en_r || s2_hit_r) && chk_exc_v;
  assign mem_resp_ecode_o = chk_ecode;

  // Walker reads the tag of the latest miss
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      miss_vtag_o <= '0;
    end else if (mem_resp_miss_o) begin
      miss_vtag_o <= s2_vtag;
    end
  end

  a_miss_not_exc: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(mem_resp_miss_o && mem_resp_exc_v_o)
  );

  a_fill_blocks_cmd: assert property (
    @(posedge clk_i) disable iff (reset_i)
    tlb_fill_v_i |-> !mmu_cmd_ready_o
  );

endmodule

// ==== testbench/mmu_tb_checks.svh ====
// Compare, failure and handshake-wait tasks, included inside the MMU testbench module
`ifndef MMU_TB_CHECKS_SVH
`define MMU_TB_CHECKS_SVH

task automatic fail_stop(input string why);
  $display("%s", why);
  $display("Simulation failed");
  $fatal(1);
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("FAIL %s: expected %b, actual %b", name, exp, act);
    fail_stop("Flag mismatch");
  end
endtask

task automatic check_ptag(input string name, input ptag_u exp, input ptag_u act);
  if (act.ppn !== exp.ppn) begin
    $display("FAIL %s: expected %h, actual %h", name, exp.ppn, act.ppn);
    fail_stop("Physical tag mismatch");
  end
endtask

task automatic check_ecode(input string name, input ecode_e exp, input ecode_e act);
  if (act !== exp) begin
    $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
    fail_stop("Exception code mismatch");
  end
endtask

task automatic check_vtag(input string name, input logic [vtag_width_lp-1:0] exp,
                          input logic [vtag_width_lp-1:0] act);
  if (act !== exp) begin
    $display("FAIL %s: expected %h, actual %h", name, exp, act);
    fail_stop("Miss tag mismatch");
  end
endtask

// Called at the edge where valid went high, returns at the accepting edge
task automatic wait_accept();
  int n;
  n = 0;
  do begin
    @(posedge clk_i);
    n++;
    if (n > 50) fail_stop("Timeout waiting for the command to be accepted");
  end while (!mmu_cmd_ready_o);
endtask

`endif

// ==== testbench/mmu_tb.sv ====
`timescale 1ns/10ps
// Self-checking testbench for the data-side MMU, run as the simulation top
module mmu_tb;
  import mmu_pkg::*;

  typedef struct packed {
    ptag_u                    ptag;
    logic [vtag_width_lp-1:0] vtag;
    logic                     miss;
    logic                     exc_v;
    ecode_e                   ecode;
    logic                     chk_ptag;
  } resp_s;

  logic clk_i, reset_i;
  logic mmu_cmd_v_i, mmu_cmd_ready_o, chk_poison_i;
  mem_op_e mmu_cmd_op_i;
  logic [vaddr_width_lp-1:0] mmu_cmd_vaddr_i;
  priv_e priv_mode_i;
  logic mstatus_sum_i, translation_en_i, uncached_mode_i;
  logic dtlb_flush_i, tlb_fill_v_i;
  logic [vtag_width_lp-1:0] tlb_fill_vtag_i, miss_vtag_o;
  pte_leaf_s tlb_fill_entry_i;
  logic mem_resp_v_o, mem_resp_miss_o, mem_resp_exc_v_o;
  logic [ptag_width_lp-1:0] mem_resp_ptag_o;
  ecode_e mem_resp_ecode_o;

  integer seed = 32'hf12a_f3ce;
  string cur_test = "reset";
  int cyc = 0;

  // TLB model
  logic [dtlb_els_lp-1:0] m_valid = '0;
  logic [vtag_width_lp-1:0] m_tag [dtlb_els_lp];
  pte_leaf_s m_entry [dtlb_els_lp];
  logic [dtlb_idx_width_lp-1:0] m_victim = '0;
  logic [vtag_width_lp-1:0] m_miss_vtag = '0;

  resp_s exp_q [$];
  string name_q [$];
  int due_q [$];
  logic st1_v = 1'b0;
  resp_s st1_e;
  string st1_name;

  mmu_top uut (.*);

  `include "mmu_tb_checks.svh"

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  function automatic priv_e rand_priv();
    case (rand32() % 32'd3)
      0: rand_priv = e_priv_u;
      1: rand_priv = e_priv_s;
      default: rand_priv = e_priv_m;
    endcase
  endfunction

  function automatic int model_find(input logic [vtag_width_lp-1:0] tag);
    model_find = -1;
    for (int i = 0; i < dtlb_els_lp; i++) begin
      if (m_valid[i] && m_tag[i] == tag) model_find = i;
    end
  endfunction

  // Expected response from the translation and permission rules
  function automatic resp_s ref_resp(input mem_op_e op, input logic [vaddr_width_lp-1:0] va,
                                     input priv_e priv, input logic sum, input logic tr,
                                     input logic uc, input logic hit, input pte_leaf_s ent);
    resp_s r;
    logic pf;
    logic af;
    logic unc;
    r = '0;
    r.vtag = va[vaddr_width_lp-1:page_offset_width_lp];
    r.ptag.ppn = tr ? ent.ptag : {1'b0, r.vtag};
    if (op == e_op_fencei) return r;
    if (tr && !hit) begin
      r.miss = 1'b1;
      return r;
    end
    r.chk_ptag = 1'b1;
    pf = tr && (((priv == e_priv_s) && !sum && ent.u) || ((priv == e_priv_u) && !ent.u)
         || ((op == e_op_store) && !(ent.w && ent.d)));
    unc = (r.ptag.ppn[27:25] != 3'd0) || (r.ptag.ppn[24:0] < 25'h008_0000);
    af = (r.ptag.ppn[27:25] > 3'd1) || (uc && !unc);
    r.exc_v = pf || af;
    if (pf) r.ecode = (op == e_op_store) ? e_store_page_fault : e_load_page_fault;
    else r.ecode = (op == e_op_store) ? e_store_access_fault : e_load_access_fault;
    return r;
  endfunction

  task automatic update_model();
    int idx;
    idx = model_find(tlb_fill_vtag_i);
    if (tlb_fill_v_i) begin
      if (idx < 0) begin
        idx = int'(m_victim);
        m_victim = m_victim + 1'b1;
      end
      m_tag[idx] = tlb_fill_vtag_i;
      m_entry[idx] = tlb_fill_entry_i;
      m_valid[idx] = 1'b1;
    end
    if (dtlb_flush_i) m_valid = '0;
  endtask

  // Compare on the falling edge, away from the driving edge
  always @(negedge clk_i) begin : compare_proc
    resp_s e;
    string nm;
    int idx;
    cyc++;
    if (!reset_i) begin
      check_flag("ready", !tlb_fill_v_i, mmu_cmd_ready_o);
      check_vtag("miss_vtag", m_miss_vtag, miss_vtag_o);
      if (mem_resp_v_o) begin
        if (exp_q.size() == 0) fail_stop("Response arrived with no command in flight");
        e = exp_q.pop_front();
        nm = name_q.pop_front();
        if (due_q.pop_front() != cyc) fail_stop("Response arrived in the wrong cycle");
        check_flag({nm, " miss"}, e.miss, mem_resp_miss_o);
        check_flag({nm, " exc_v"}, e.exc_v, mem_resp_exc_v_o);
        if (e.chk_ptag) check_ptag({nm, " ptag"}, e.ptag, mem_resp_ptag_o);
        if (e.exc_v) check_ecode({nm, " ecode"}, e.ecode, mem_resp_ecode_o);
        if (e.miss) m_miss_vtag = e.vtag;
      end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
        fail_stop("Expected response did not arrive");
      end
      if (st1_v && !chk_poison_i) begin
        exp_q.push_back(st1_e);
        name_q.push_back(st1_name);
        due_q.push_back(cyc + 1);
      end
      st1_v = mmu_cmd_v_i && mmu_cmd_ready_o;
      if (st1_v) begin
        idx = model_find(mmu_cmd_vaddr_i[vaddr_width_lp-1:page_offset_width_lp]);
        st1_e = ref_resp(mmu_cmd_op_i, mmu_cmd_vaddr_i, priv_mode_i, mstatus_sum_i,
                         translation_en_i, uncached_mode_i, idx >= 0,
                         (idx >= 0) ? m_entry[idx] : '0);
        st1_name = cur_test;
      end
      update_model();
    end
  end

  task automatic set_ctrl(input logic tr, input logic uc, input priv_e pm, input logic sum);
    translation_en_i <= tr;
    uncached_mode_i <= uc;
    priv_mode_i <= pm;
    mstatus_sum_i <= sum;
  endtask

  task automatic drive_cmd(input mem_op_e op, input logic [vaddr_width_lp-1:0] va,
                           input logic poison);
    mmu_cmd_v_i <= 1'b1;
    mmu_cmd_op_i <= op;
    mmu_cmd_vaddr_i <= va;
    wait_accept();
    mmu_cmd_v_i <= 1'b0;
    chk_poison_i <= poison;
  endtask

  task automatic fill_tlb(input logic [vtag_width_lp-1:0] tag, input pte_leaf_s ent);
    tlb_fill_v_i <= 1'b1;
    tlb_fill_vtag_i <= tag;
    tlb_fill_entry_i <= ent;
    chk_poison_i <= 1'b0;
    @(posedge clk_i);
    tlb_fill_v_i <= 1'b0;
  endtask

  // Command raised in the same cycle as a fill, so it stalls once
  task automatic cmd_with_fill(input logic [vaddr_width_lp-1:0] va,
                               input logic [vtag_width_lp-1:0] tag, input pte_leaf_s ent);
    mmu_cmd_v_i <= 1'b1;
    mmu_cmd_op_i <= e_op_load;
    mmu_cmd_vaddr_i <= va;
    fill_tlb(tag, ent);
    wait_accept();
    mmu_cmd_v_i <= 1'b0;
  endtask

  task automatic idle(input int n);
    chk_poison_i <= 1'b0;
    dtlb_flush_i <= 1'b0;
    repeat (n) @(posedge clk_i);
  endtask

  function automatic mem_op_e rand_ls();
    rand_ls = rand32() % 32'd2 == 0 ? e_op_load : e_op_store;
  endfunction

  initial begin : stimulus
    logic [31:0] r;
    logic [vtag_width_lp-1:0] tag;
    pte_leaf_s ent;
    int n;
    reset_i = 1'b1;
    mmu_cmd_v_i = 1'b0;
    mmu_cmd_op_i = e_op_load;
    mmu_cmd_vaddr_i = '0;
    chk_poison_i = 1'b0;
    priv_mode_i = e_priv_m;
    mstatus_sum_i = 1'b0;
    translation_en_i = 1'b0;
    uncached_mode_i = 1'b0;
    dtlb_flush_i = 1'b0;
    tlb_fill_v_i = 1'b0;
    tlb_fill_vtag_i = '0;
    tlb_fill_entry_i = '0;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    idle(2);

    cur_test = "bare";
    set_ctrl(1'b0, 1'b0, e_priv_m, 1'b0);
    repeat (20) drive_cmd(rand_ls(), {27'(rand32()), 12'(rand32())}, 1'b0);
    cur_test = "bare_uncached";
    set_ctrl(1'b0, 1'b1, e_priv_m, 1'b0);
    repeat (20) drive_cmd(rand_ls(), {27'(rand32()), 12'(rand32())}, 1'b0);
    idle(4);

    // Ten fills into eight entries evict the first two
    cur_test = "tlb_fill";
    set_ctrl(1'b1, 1'b0, e_priv_m, 1'b0);
    for (int i = 0; i < 10; i++) begin
      fill_tlb(27'h100 + 27'(i), '{ptag: 28'h008_0000 + 28'(i), u: 1'b0, w: 1'b1, d: 1'b1});
    end
    for (int i = 0; i < 12; i++) drive_cmd(e_op_load, {27'h100 + 27'(i), 12'h010}, 1'b0);
    idle(3);
    cur_test = "tlb_flush";
    dtlb_flush_i <= 1'b1;
    @(posedge clk_i);
    dtlb_flush_i <= 1'b0;
    for (int i = 0; i < 10; i++) drive_cmd(e_op_store, {27'h100 + 27'(i), 12'h000}, 1'b0);

    cur_test = "page_fault";
    for (int i = 0; i < 40; i++) begin
      r = rand32();
      tag = 27'h200 + 27'(i % 8);
      fill_tlb(tag, '{ptag: 28'(rand32()), u: r[0], w: r[1], d: r[2]});
      set_ctrl(1'b1, r[3], rand_priv(), r[4]);
      drive_cmd(rand_ls(), {tag, r[15:4]}, 1'b0);
    end

    cur_test = "domain";
    for (int i = 0; i < 40; i++) begin
      r = rand32();
      ent = '{ptag: {r[2:0], 25'h008_0000 + 25'(r[8:3]) - 25'd32}, u: 1'b0, w: 1'b1, d: 1'b1};
      fill_tlb(27'h300, ent);
      set_ctrl(1'b1, r[9], e_priv_m, 1'b0);
      drive_cmd(rand_ls(), {27'h300, r[21:10]}, 1'b0);
    end

    cur_test = "pipeline";
    for (int i = 0; i < 60; i++) begin
      r = rand32();
      set_ctrl(r[4], r[5], rand_priv(), r[6]);
      tag = 27'h100 + 27'(r[11:8] % 4'd12);
      case (r[1:0])
        2'd0: cmd_with_fill({tag, r[23:12]}, 27'h100 + 27'(r[14:12]),
                            '{ptag: 28'(rand32()), u: r[24], w: r[25], d: r[26]});
        2'd1: drive_cmd(e_op_fencei, {tag, r[23:12]}, r[2]);
        default: drive_cmd(rand_ls(), {tag, r[23:12]}, r[2]);
      endcase
    end
    idle(1);

    n = 0;
    while (st1_v || exp_q.size() != 0) begin
      @(posedge clk_i);
      n++;
      if (n > 20) fail_stop("Timeout waiting for outstanding responses");
    end
    idle(3);
    if (exp_q.size() != 0) begin
      fail_stop("Responses still outstanding at the end of the run");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule
